//--- raster_fixed_pkg.sv
// Fixed-point coordinate and color formats shared by the sample iterator RTL and its testbench
package raster_fixed_pkg;

    // Total bits in one coordinate or one color channel
    parameter int sigfig = 24;

    // Fraction bits; the low radix bits sit below the binary point
    parameter int radix = 10;

    // Coordinates per vertex, ordered x, y, z
    parameter int axis = 3;

    // Signed screen coordinate
    // Bits [sigfig-1:radix] hold the integer pixel part
    // Bits [radix-1:0] hold the sub-pixel fraction
    // One pixel is 1 << radix raw units, so 1024 here
    typedef logic signed [sigfig-1:0] coord_t;

    // Unsigned color channel, same width and fraction split as a coordinate
    typedef logic [sigfig-1:0] color_t;

    // Vertex layout inside a triangle array
    //   tri[v][0] is x of vertex v
    //   tri[v][1] is y of vertex v
    //   tri[v][2] is z of vertex v
    // The iterator never looks inside the vertices, it only carries them

    // Box corners travel as four separate coordinates
    //   min x / min y is the lower-left start corner
    //   max x / max y is the upper-right end corner
    // Corners are expected on the sample grid of the active MSAA mode

    // Sample coordinates use the same coord_t format as the box
    // so the edge compares are plain signed compares

    // Typical magnitudes
    //   a 2048 pixel screen needs 11 integer bits plus sign
    //   sigfig - radix = 14 leaves headroom for guard-band samples
    // Step sizes stay well below one pixel so no compare overflows
    // Sign matters for guard-band boxes left of or below the origin

endpackage

//--- raster_ctrl_pkg.sv
// Iterator FSM states and MSAA mode encoding used by the sample iterator and its testbench
package raster_ctrl_pkg;

    // Iterator FSM
    //   WAIT_STATE  idle, watching for a valid box
    //   TEST_STATE  emitting one sample per clock
    typedef enum logic {
        WAIT_STATE = 1'b0,
        TEST_STATE = 1'b1
    } iter_state_t;

    // MSAA mode, one-hot
    // Bit position doubles as the sample interval exponent
    //   1x   one sample per pixel, step of a whole pixel
    //   4x   step of half a pixel
    //   16x  step of a quarter pixel
    //   64x  step of an eighth of a pixel
    typedef enum logic [3:0] {
        MSAA_1X  = 4'b1000,
        MSAA_4X  = 4'b0100,
        MSAA_16X = 4'b0010,
        MSAA_64X = 4'b0001
    } msaa_t;

    // Step rule
    // Shifting the one-hot code left by radix - 3 lands bit 3 on the
    // one-pixel weight, so the code itself scales to the step
    //   MSAA_1X  -> 1024 raw units
    //   MSAA_4X  ->  512 raw units
    //   MSAA_16X ->  256 raw units
    //   MSAA_64X ->  128 raw units
    parameter int step_shift = raster_fixed_pkg::radix - 3;

    // No code other than the four above is legal on the subsample input
    // Upstream keeps it constant for the whole box

endpackage

//--- iter_control.sv
// Wait/test FSM of the sample iterator; issues stepper commands and holds the triangle payload
`timescale 1ns/10ps

module iter_control #(
    // Vertices per triangle
    parameter int verts = 3,
    // Color channels per triangle
    parameter int colors = 3
) (
    input  logic                       clk,
    input  logic                       rst,

    // New box offered by upstream
    input  logic                       valid_tri,

    // Stepper reports the current sample is the last one
    input  logic                       at_end,

    // Payload offered with the box
    input  raster_fixed_pkg::coord_t   tri_in [verts-1:0][raster_fixed_pkg::axis-1:0],
    input  raster_fixed_pkg::color_t   color_in [colors-1:0],

    // Payload held for the whole box
    output raster_fixed_pkg::coord_t   tri_out [verts-1:0][raster_fixed_pkg::axis-1:0],
    output raster_fixed_pkg::color_t   color_out [colors-1:0],

    // Stepper commands
    output logic                       load,
    output logic                       advance,

    // Registered Moore outputs
    output logic                       valid_samp,
    output logic                       halt_n
);

    raster_ctrl_pkg::iter_state_t state;
    raster_ctrl_pkg::iter_state_t next_state;

    // Accept a box only while idle
    // valid_tri is a don't-care in TEST_STATE
    assign load = (state == raster_ctrl_pkg::WAIT_STATE) && valid_tri;

    // Keep stepping until the stepper flags the last sample
    assign advance = (state == raster_ctrl_pkg::TEST_STATE) && !at_end;

    // Next state
    always_comb begin
        next_state = state;
        case (state)
            raster_ctrl_pkg::WAIT_STATE: begin
                if (valid_tri) begin
                    next_state = raster_ctrl_pkg::TEST_STATE;
                end
            end
            raster_ctrl_pkg::TEST_STATE: begin
                // Last sample shown this cycle, idle next
                if (at_end) begin
                    next_state = raster_ctrl_pkg::WAIT_STATE;
                end
            end
            default: begin
                next_state = raster_ctrl_pkg::WAIT_STATE;
            end
        endcase
    end

    // State plus registered outputs
    // Outputs follow the next state so they line up with the sample registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= raster_ctrl_pkg::WAIT_STATE;
            valid_samp <= 1'b0;
            halt_n     <= 1'b1;
        end else begin
            state      <= next_state;
            valid_samp <= (next_state == raster_ctrl_pkg::TEST_STATE);
            // Hold upstream for every cycle a sample is out
            halt_n     <= (next_state != raster_ctrl_pkg::TEST_STATE);
        end
    end

    // Payload capture
    // Taken together with the box, then frozen until the next accept
    always_ff @(posedge clk) begin
        if (load) begin
            tri_out   <= tri_in;
            color_out <= color_in;
        end
    end

endmodule

//--- raster_stepper.sv
// Sample stepper of the iterator; holds the box, walks the sample grid and flags the last sample
`timescale 1ns/10ps

module raster_stepper #(
    // Scan order, 0 raster and 1 serpentine
    parameter int serpentine = 0
) (
    input  logic                       clk,
    input  logic                       rst,

    // Capture box, start at lower-left
    input  logic                       load,

    // Move to the next sample
    input  logic                       advance,

    // Box from upstream, sampled on load
    input  raster_fixed_pkg::coord_t   box_min_x,
    input  raster_fixed_pkg::coord_t   box_min_y,
    input  raster_fixed_pkg::coord_t   box_max_x,
    input  raster_fixed_pkg::coord_t   box_max_y,

    // MSAA mode selects the sample interval
    input  raster_ctrl_pkg::msaa_t     subsample,

    // Current candidate sample
    output raster_fixed_pkg::coord_t   sample_x,
    output raster_fixed_pkg::coord_t   sample_y,

    // Current sample ends the top row
    output logic                       at_end
);

    // Captured box
    raster_fixed_pkg::coord_t box_x0;
    raster_fixed_pkg::coord_t box_y0;
    raster_fixed_pkg::coord_t box_x1;
    raster_fixed_pkg::coord_t box_y1;

    // Sample interval in raw fixed-point units
    raster_fixed_pkg::coord_t step;

    // Next sample
    raster_fixed_pkg::coord_t next_x;
    raster_fixed_pkg::coord_t next_y;

    // Row walk direction, high while moving left
    logic move_left;

    // Edge flags
    logic row_end;
    logic top_row;

    // One-hot code scaled straight into the step
    // 1x gives 1024, 4x 512, 16x 256, 64x 128
    assign step = {{(raster_fixed_pkg::sigfig - $bits(subsample)){1'b0}}, subsample}
                  << raster_ctrl_pkg::step_shift;

    // Row end depends on the walk direction
    // Moving right, stop at or past the max edge
    // Moving left, stop at or below the min edge
    assign row_end = move_left ? (sample_x <= box_x0) : (sample_x >= box_x1);

    // Top row once y reaches the max edge
    assign top_row = (sample_y >= box_y1);

    // Last sample of the box
    assign at_end = row_end && top_row;

    // Next sample select
    always_comb begin
        if (load) begin
            // Fresh box starts at its lower-left corner
            next_x = box_min_x;
            next_y = box_min_y;
        end else if (advance) begin
            if (row_end) begin
                // Up one row
                next_y = sample_y + step;
                if (serpentine != 0) begin
                    // Serpentine keeps x at the edge just reached
                    next_x = sample_x;
                end else begin
                    // Raster order returns to the left edge
                    next_x = box_x0;
                end
            end else begin
                // Along the row, one interval
                next_y = sample_y;
                if (move_left) begin
                    next_x = sample_x - step;
                end else begin
                    next_x = sample_x + step;
                end
            end
        end else begin
            // Idle, park on the lower-left corner of the held box
            next_x = box_x0;
            next_y = box_y0;
        end
    end

    // Box registers, loaded once per box
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            box_x0 <= '0;
            box_y0 <= '0;
            box_x1 <= '0;
            box_y1 <= '0;
        end else if (load) begin
            box_x0 <= box_min_x;
            box_y0 <= box_min_y;
            box_x1 <= box_max_x;
            box_y1 <= box_max_y;
        end
    end

    // Sample registers, drive the outputs directly
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sample_x <= '0;
            sample_y <= '0;
        end else begin
            sample_x <= next_x;
            sample_y <= next_y;
        end
    end

    // Direction bit only exists for serpentine order
    generate
        if (serpentine != 0) begin : g_snake
            logic dir_q;

            always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                    dir_q <= 1'b0;
                end else if (advance && row_end) begin
                    // Flip at every row change
                    dir_q <= ~dir_q;
                end else if (!advance) begin
                    // New box or idle, start rightward
                    dir_q <= 1'b0;
                end
            end

            assign move_left = dir_q;
        end else begin : g_raster
            // Raster order always walks right
            assign move_left = 1'b0;
        end
    endgenerate

endmodule

//--- sample_iter_top.sv
// Subsample raster iterator top level; connects the FSM and the stepper and passes parameters down
`timescale 1ns/10ps

module sample_iter_top #(
    // Vertices per triangle
    parameter int verts = 3,
    // Color channels per triangle
    parameter int colors = 3,
    // Scan order, 0 raster and 1 serpentine
    parameter int serpentine = 0
) (
    input  logic                       clk,
    input  logic                       rst,

    // Triangle and colors from the bounding box stage
    input  raster_fixed_pkg::coord_t   tri_in [verts-1:0][raster_fixed_pkg::axis-1:0],
    input  raster_fixed_pkg::color_t   color_in [colors-1:0],

    // Bounding box of the triangle
    input  raster_fixed_pkg::coord_t   box_min_x,
    input  raster_fixed_pkg::coord_t   box_min_y,
    input  raster_fixed_pkg::coord_t   box_max_x,
    input  raster_fixed_pkg::coord_t   box_max_y,

    // Box and triangle valid
    input  logic                       valid_tri,

    // MSAA mode, constant during a box
    input  raster_ctrl_pkg::msaa_t     subsample,

    // Held triangle and colors, travel with every sample
    output raster_fixed_pkg::coord_t   tri_out [verts-1:0][raster_fixed_pkg::axis-1:0],
    output raster_fixed_pkg::color_t   color_out [colors-1:0],

    // Candidate sample location
    output raster_fixed_pkg::coord_t   sample_x,
    output raster_fixed_pkg::coord_t   sample_y,

    // Sample valid strobe
    output logic                       valid_samp,

    // Upstream hold, low while a box is iterated
    output logic                       halt_n
);

    // Stepper commands from the FSM
    logic load;
    logic advance;

    // Last sample of the box reached
    logic at_end;

    // FSM and payload holding
    iter_control #(
        .verts  (verts),
        .colors (colors)
    ) i_iter_control (
        .clk        (clk),
        .rst        (rst),
        .valid_tri  (valid_tri),
        .at_end     (at_end),
        .tri_in     (tri_in),
        .color_in   (color_in),
        .tri_out    (tri_out),
        .color_out  (color_out),
        .load       (load),
        .advance    (advance),
        .valid_samp (valid_samp),
        .halt_n     (halt_n)
    );

    // Box capture and sample stepping
    raster_stepper #(
        .serpentine (serpentine)
    ) i_raster_stepper (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .advance   (advance),
        .box_min_x (box_min_x),
        .box_min_y (box_min_y),
        .box_max_x (box_max_x),
        .box_max_y (box_max_y),
        .subsample (subsample),
        .sample_x  (sample_x),
        .sample_y  (sample_y),
        .at_end    (at_end)
    );

endmodule

//--- sample_iter_properties.sv
// Concurrent checks on the sample stepper, attached to every raster_stepper instance by bind
`timescale 1ns/10ps

module sample_iter_properties (
    input logic                     clk,
    input logic                     rst,
    input logic                     load,
    input logic                     advance,
    input logic                     at_end,
    input raster_fixed_pkg::coord_t box_min_x,
    input raster_fixed_pkg::coord_t box_min_y,
    input raster_fixed_pkg::coord_t box_x0,
    input raster_fixed_pkg::coord_t box_y0,
    input raster_fixed_pkg::coord_t box_x1,
    input raster_fixed_pkg::coord_t box_y1,
    input raster_fixed_pkg::coord_t sample_x,
    input raster_fixed_pkg::coord_t sample_y
);

    // Shadow of the FSM state seen from the stepper commands
    raster_ctrl_pkg::iter_state_t seen_state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seen_state <= raster_ctrl_pkg::WAIT_STATE;
        end else if (load) begin
            seen_state <= raster_ctrl_pkg::TEST_STATE;
        end else if (seen_state == raster_ctrl_pkg::TEST_STATE && at_end) begin
            seen_state <= raster_ctrl_pkg::WAIT_STATE;
        end
    end

    // First sample is the lower-left corner
    assert property (@(posedge clk) disable iff (rst)
        load |=> (sample_x == $past(box_min_x)) && (sample_y == $past(box_min_y)))
        else $error("first sample is not the loaded lower-left corner");

    // Stepping never leaves the box
    assert property (@(posedge clk) disable iff (rst)
        advance |-> (sample_x >= box_x0) && (sample_x <= box_x1) &&
                    (sample_y >= box_y0) && (sample_y <= box_y1))
        else $error("sample outside the box while stepping");

    // Last sample on the top row
    // Grid-aligned corners put it exactly on the max edge, never past it
    assert property (@(posedge clk) disable iff (rst)
        at_end |-> (sample_y == box_y1))
        else $error("at_end off the top row");

    // Stepping only inside a box
    assert property (@(posedge clk) disable iff (rst)
        advance |-> (seen_state == raster_ctrl_pkg::TEST_STATE))
        else $error("advance outside an accepted box");

endmodule

bind raster_stepper sample_iter_properties i_props (
    .clk(clk), .rst(rst), .load(load), .advance(advance), .at_end(at_end),
    .box_min_x(box_min_x), .box_min_y(box_min_y),
    .box_x0(box_x0), .box_y0(box_y0), .box_x1(box_x1), .box_y1(box_y1),
    .sample_x(sample_x), .sample_y(sample_y)
);

//--- tb_sample_iter.sv
// Testbench for the sample iterator; runs a box table through raster and serpentine DUTs and checks
`timescale 1ns/10ps

module tb_sample_iter;

    localparam int verts = 3;
    localparam int colors = 3;
    localparam int axis = raster_fixed_pkg::axis;
    localparam int timeout_cycles = 200;
    localparam int num_tests = 7;

    // One box with its mode and expected grid size
    typedef struct packed {
        raster_fixed_pkg::coord_t min_x;
        raster_fixed_pkg::coord_t min_y;
        raster_fixed_pkg::coord_t max_x;
        raster_fixed_pkg::coord_t max_y;
        raster_ctrl_pkg::msaa_t   code;
        int                       cols;
        int                       rows;
    } entry_t;

    logic clk;
    logic rst;
    raster_fixed_pkg::coord_t tri_in [verts-1:0][axis-1:0];
    raster_fixed_pkg::color_t color_in [colors-1:0];
    raster_fixed_pkg::coord_t box_min_x;
    raster_fixed_pkg::coord_t box_min_y;
    raster_fixed_pkg::coord_t box_max_x;
    raster_fixed_pkg::coord_t box_max_y;
    logic valid_tri;
    raster_ctrl_pkg::msaa_t subsample;

    // Raster order DUT outputs
    raster_fixed_pkg::coord_t tri_out [verts-1:0][axis-1:0];
    raster_fixed_pkg::color_t color_out [colors-1:0];
    raster_fixed_pkg::coord_t sample_x;
    raster_fixed_pkg::coord_t sample_y;
    logic valid_samp;
    logic halt_n;

    // Serpentine DUT outputs
    raster_fixed_pkg::coord_t tri_out_s [verts-1:0][axis-1:0];
    raster_fixed_pkg::color_t color_out_s [colors-1:0];
    raster_fixed_pkg::coord_t sample_x_s;
    raster_fixed_pkg::coord_t sample_y_s;
    logic valid_samp_s;
    logic halt_n_s;

    entry_t tests [num_tests];
    // Expected sequences, raster and serpentine
    raster_fixed_pkg::coord_t exp_x [$];
    raster_fixed_pkg::coord_t exp_y [$];
    raster_fixed_pkg::coord_t snake_x [$];
    raster_fixed_pkg::coord_t snake_y [$];
    // Payload as offered with the box
    raster_fixed_pkg::coord_t held_tri [verts-1:0][axis-1:0];
    raster_fixed_pkg::color_t held_color [colors-1:0];

    int seed = 32'h7a51;
    int errors = 0;
    int checks = 0;
    bit timed_out = 0;

    sample_iter_top #(.verts(verts), .colors(colors), .serpentine(0)) i_dut (
        .clk(clk), .rst(rst), .tri_in(tri_in), .color_in(color_in),
        .box_min_x(box_min_x), .box_min_y(box_min_y),
        .box_max_x(box_max_x), .box_max_y(box_max_y),
        .valid_tri(valid_tri), .subsample(subsample),
        .tri_out(tri_out), .color_out(color_out),
        .sample_x(sample_x), .sample_y(sample_y),
        .valid_samp(valid_samp), .halt_n(halt_n)
    );

    sample_iter_top #(.verts(verts), .colors(colors), .serpentine(1)) i_dut_snake (
        .clk(clk), .rst(rst), .tri_in(tri_in), .color_in(color_in),
        .box_min_x(box_min_x), .box_min_y(box_min_y),
        .box_max_x(box_max_x), .box_max_y(box_max_y),
        .valid_tri(valid_tri), .subsample(subsample),
        .tri_out(tri_out_s), .color_out(color_out_s),
        .sample_x(sample_x_s), .sample_y(sample_y_s),
        .valid_samp(valid_samp_s), .halt_n(halt_n_s)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Sample interval, one pixel divided by the per-axis sample rate
    function automatic int step_for(input raster_ctrl_pkg::msaa_t code);
        int pixel;
        pixel = 1 << raster_fixed_pkg::radix;
        case (code)
            raster_ctrl_pkg::MSAA_4X:  return pixel / 2;
            raster_ctrl_pkg::MSAA_16X: return pixel / 4;
            raster_ctrl_pkg::MSAA_64X: return pixel / 8;
            default:                   return pixel;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [raster_fixed_pkg::sigfig-1:0] got,
                               input logic [raster_fixed_pkg::sigfig-1:0] want);
        checks++;
        assert (got === want) else begin
            $display("[FAIL] %s got %h expected %h", name, got, want);
            errors++;
        end
    endtask

    // Walk the box by the stepping rules, append to the matching queues
    task automatic model_scan(input entry_t e, input bit snake);
        int x;
        int y;
        int step;
        int guard;
        int x0;
        int x1;
        int y1;
        bit left;
        step = step_for(e.code);
        x0 = $signed(e.min_x);
        x1 = $signed(e.max_x);
        y1 = $signed(e.max_y);
        x = x0;
        y = $signed(e.min_y);
        left = 1'b0;
        for (guard = 0; guard < 4096; guard++) begin
            if (snake) begin
                snake_x.push_back(x);
                snake_y.push_back(y);
            end else begin
                exp_x.push_back(x);
                exp_y.push_back(y);
            end
            if (left ? (x <= x0) : (x >= x1)) begin
                if (y >= y1) break;
                y = y + step;
                // Serpentine keeps x and turns around, raster goes back left
                if (snake) begin
                    left = !left;
                end else begin
                    x = x0;
                end
            end else begin
                x = left ? x - step : x + step;
            end
        end
    endtask

    task automatic randomize_payload();
        for (int v = 0; v < verts; v++)
            for (int a = 0; a < axis; a++)
                tri_in[v][a] = $random(seed);
        for (int c = 0; c < colors; c++)
            color_in[c] = $random(seed);
    endtask

    // Both DUTs must still show the payload taken with the box
    task automatic check_payload();
        for (int v = 0; v < verts; v++) begin
            for (int a = 0; a < axis; a++) begin
                check_value($sformatf("i_dut.tri_out[%0d][%0d]", v, a), tri_out[v][a],
                            held_tri[v][a]);
                check_value($sformatf("i_dut_snake.tri_out[%0d][%0d]", v, a), tri_out_s[v][a],
                            held_tri[v][a]);
            end
        end
        for (int c = 0; c < colors; c++) begin
            check_value($sformatf("i_dut.color_out[%0d]", c), color_out[c], held_color[c]);
            check_value($sformatf("i_dut_snake.color_out[%0d]", c), color_out_s[c], held_color[c]);
        end
    endtask

    // Idle wait, both DUTs releasing upstream
    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (!(halt_n && halt_n_s) && cycles < timeout_cycles) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!(halt_n && halt_n_s)) begin
            $display("Timeout: halt_n stayed low for %0d cycles before a new box", cycles);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        int n;
        int cycles;
        int tests_run;
        entry_t e;
        rst = 1'b1;
        valid_tri = 1'b0;
        box_min_x = '0;
        box_min_y = '0;
        box_max_x = '0;
        box_max_y = '0;
        subsample = raster_ctrl_pkg::MSAA_1X;
        for (int v = 0; v < verts; v++)
            for (int a = 0; a < axis; a++)
                tri_in[v][a] = '0;
        for (int c = 0; c < colors; c++)
            color_in[c] = '0;
        tests_run = 0;

        // min x, min y, max x, max y, mode, columns, rows
        tests[0] = '{0, 0, 3072, 2048, raster_ctrl_pkg::MSAA_1X, 4, 3};
        tests[1] = '{1024, 512, 2048, 2048, raster_ctrl_pkg::MSAA_4X, 3, 4};
        tests[2] = '{-512, -256, 512, 0, raster_ctrl_pkg::MSAA_16X, 5, 2};
        tests[3] = '{128, 256, 384, 512, raster_ctrl_pkg::MSAA_64X, 3, 3};
        tests[4] = '{2048, 1024, 2048, 1024, raster_ctrl_pkg::MSAA_1X, 1, 1};
        tests[5] = '{0, 0, 0, 768, raster_ctrl_pkg::MSAA_16X, 1, 4};
        tests[6] = '{-1024, -1024, 0, -1024, raster_ctrl_pkg::MSAA_4X, 3, 1};

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;
        // Idle after reset, no box offered yet
        check_value("i_dut.valid_samp", valid_samp, 1'b0);
        check_value("i_dut_snake.valid_samp", valid_samp_s, 1'b0);
        check_value("i_dut.halt_n", halt_n, 1'b1);
        check_value("i_dut_snake.halt_n", halt_n_s, 1'b1);

        for (int t = 0; t < num_tests; t++) begin
            int start_errors;
            e = tests[t];
            start_errors = errors;
            wait_idle();
            if (timed_out) break;
            exp_x.delete();
            exp_y.delete();
            snake_x.delete();
            snake_y.delete();
            model_scan(e, 1'b0);
            model_scan(e, 1'b1);
            box_min_x = e.min_x;
            box_min_y = e.min_y;
            box_max_x = e.max_x;
            box_max_y = e.max_y;
            subsample = e.code;
            randomize_payload();
            held_tri = tri_in;
            held_color = color_in;
            valid_tri = 1'b1;
            n = 0;
            cycles = 0;
            // Collect samples until halt_n comes back
            do begin
                @(posedge clk);
                #1;
                cycles++;
                if (valid_samp) begin
                    if (n < exp_x.size()) begin
                        check_value("i_dut.sample_x", sample_x, exp_x[n]);
                        check_value("i_dut.sample_y", sample_y, exp_y[n]);
                        check_value("i_dut_snake.sample_x", sample_x_s, snake_x[n]);
                        check_value("i_dut_snake.sample_y", sample_y_s, snake_y[n]);
                    end
                    check_value("i_dut_snake.valid_samp", valid_samp_s, 1'b1);
                    check_value("i_dut.halt_n", halt_n, 1'b0);
                    check_value("i_dut_snake.halt_n", halt_n_s, 1'b0);
                    check_payload();
                    n++;
                    // Upstream misbehaves while held, nothing may change
                    randomize_payload();
                    valid_tri = n[0];
                end
            end while (valid_samp && cycles < timeout_cycles);
            valid_tri = 1'b0;
            if (valid_samp) begin
                $display("Timeout: test %0d still emitting samples after %0d cycles", t, cycles);
                timed_out = 1'b1;
                break;
            end
            check_value("i_dut.halt_n", halt_n, 1'b1);
            check_value("i_dut_snake.halt_n", halt_n_s, 1'b1);
            check_value("i_dut_snake.valid_samp", valid_samp_s, 1'b0);
            check_value("sample count", n, e.cols * e.rows);
            // One idle edge with valid_tri low
            @(posedge clk);
            #1;
            check_value("i_dut.valid_samp", valid_samp, 1'b0);
            check_value("i_dut_snake.valid_samp", valid_samp_s, 1'b0);
            tests_run++;
            $display("test %0d mode %b box %0dx%0d: %0d samples, %s", t, e.code, e.cols, e.rows,
                     n, (errors == start_errors) ? "ok" : "mismatch");
        end

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- sim.f
raster_fixed_pkg.sv
raster_ctrl_pkg.sv
iter_control.sv
raster_stepper.sv
sample_iter_top.sv
sample_iter_properties.sv
tb_sample_iter.sv
